//--- logic/smc_bus_pkg.sv
/*
 * host bus definitions for the static memory controller
 * opcode encoding and the address, data and byte lane widths
 */
`default_nettype none

package smc_bus_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------

  // word address into the sram
  localparam int ADDR_W = 16;

  // one full word per request
  localparam int DATA_W = 32;

  // one write enable per byte lane
  localparam int LANES = 4;

  // ----------------------------------------
  // request opcodes
  // ----------------------------------------

  // single word transfers only, no bursts
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } smc_op_e;

endpackage : smc_bus_pkg

`default_nettype wire

//--- logic/smc_cycle_fsm.sv
/*
 * sram cycle sequencer
 * walks setup, strobe and hold with a per phase down counter and
 * drives chip select, output enable, raw write strobes and capture
 */
`timescale 1ns/100ps
`default_nettype none

module smc_cycle_fsm #(
  parameter logic [smc_timing_pkg::PHASE_W-1:0] SETUP_CYCLES  = 4'd2,
  parameter logic [smc_timing_pkg::PHASE_W-1:0] STROBE_CYCLES = 4'd3,
  parameter logic [smc_timing_pkg::PHASE_W-1:0] HOLD_CYCLES   = 4'd1
) (
  input  wire                                  hclk,
  input  wire                                  rst,
  // held request
  input  wire                                  held_valid,
  input  wire smc_bus_pkg::smc_op_e            held_op,
  input  wire [smc_bus_pkg::LANES-1:0]         held_be,
  // raw strobes to the write enable stage
  output logic                                 r_full,
  output logic                                 n_r_wr,
  output logic [smc_bus_pkg::LANES-1:0]        n_r_we,
  // registered pins
  output logic                                 smc_n_cs,
  output logic                                 smc_n_oe,
  output logic                                 mem_wdata_oe,
  // read capture and end of cycle
  output logic                                 capture,
  output logic                                 cycle_done
);

  import smc_bus_pkg::*;
  import smc_timing_pkg::*;

  smc_state_e           state;
  logic [PHASE_W-1:0]   phase_cnt;
  logic                 phase_last;
  logic                 cycle_active;
  logic                 is_write;

  // ----------------------------------------
  // state and phase counter
  // ----------------------------------------

  assign phase_last = (phase_cnt == '0);

  // counter holds remaining clocks of the current phase minus one
  // idle waits out a pending cycle_done so the old request never restarts
  always_ff @(posedge hclk)
  begin
    if (rst)
    begin
      state     <= ST_IDLE;
      phase_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (held_valid && !cycle_done)
          begin
            state     <= ST_SETUP;
            phase_cnt <= SETUP_CYCLES - 1'b1;
          end
        ST_SETUP:
          if (phase_last)
          begin
            state     <= ST_STROBE;
            phase_cnt <= STROBE_CYCLES - 1'b1;
          end
          else
            phase_cnt <= phase_cnt - 1'b1;
        ST_STROBE:
          if (phase_last)
          begin
            state     <= ST_HOLD;
            phase_cnt <= HOLD_CYCLES - 1'b1;
          end
          else
            phase_cnt <= phase_cnt - 1'b1;
        ST_HOLD:
          if (phase_last)
            state <= ST_DONE;
          else
            phase_cnt <= phase_cnt - 1'b1;
        // single turnaround clock
        ST_DONE:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // raw strobes
  // ----------------------------------------

  assign cycle_active = (state == ST_SETUP) || (state == ST_STROBE) || (state == ST_HOLD);
  assign is_write     = (held_op == OP_WRITE);

  // full cycle phase, the only thing that shapes the write pulse
  assign r_full = (state == ST_STROBE);

  // raw strobes low across the whole write cycle
  assign n_r_wr = !(cycle_active && is_write);
  assign n_r_we = (cycle_active && is_write) ? ~held_be : '1;

  // ----------------------------------------
  // pin registers
  // ----------------------------------------

  // one clock behind state, same delay as the write enable stage
  always_ff @(posedge hclk)
  begin
    if (rst)
    begin
      smc_n_cs     <= 1'b1;
      smc_n_oe     <= 1'b1;
      mem_wdata_oe <= 1'b0;
      capture      <= 1'b0;
      cycle_done   <= 1'b0;
    end
    else
    begin
      smc_n_cs     <= !cycle_active;
      smc_n_oe     <= !(r_full && !is_write);
      mem_wdata_oe <= cycle_active && is_write;
      // lines up with the last clock of the oe window on the pins
      capture      <= r_full && phase_last && !is_write;
      // one clock after cs is released
      cycle_done   <= (state == ST_DONE);
    end
  end

endmodule : smc_cycle_fsm

`default_nettype wire

//--- logic/smc_rd_capture.sv
/*
 * read capture and response register
 * samples sram data at the end of the strobe and holds the
 * response until the host takes it
 */
`timescale 1ns/100ps
`default_nettype none

module smc_rd_capture (
  input  wire                                  hclk,
  input  wire                                  rst,
  // from the sequencer
  input  wire                                  capture,
  input  wire                                  cycle_done,
  input  wire smc_bus_pkg::smc_op_e            held_op,
  // sram data pins
  input  wire [smc_bus_pkg::DATA_W-1:0]        mem_rdata,
  // host response
  output logic                                 rsp_valid,
  input  wire                                  rsp_ready,
  output smc_bus_pkg::smc_op_e                 rsp_op,
  output logic [smc_bus_pkg::DATA_W-1:0]       rsp_rdata,
  // response pending, blocks new requests
  output logic                                 rsp_busy
);

  import smc_bus_pkg::*;

  // valid from end of cycle until the handshake
  always_ff @(posedge hclk)
  begin
    if (rst)
      rsp_valid <= 1'b0;
    else if (cycle_done)
      rsp_valid <= 1'b1;
    else if (rsp_valid && rsp_ready)
      rsp_valid <= 1'b0;
  end

  // capture only occurs while no response is pending
  // so data stays stable under back-pressure
  always_ff @(posedge hclk)
  begin
    if (capture)
      rsp_rdata <= mem_rdata;
    else if (cycle_done && (held_op == OP_WRITE))
      rsp_rdata <= '0;
    if (cycle_done)
      rsp_op <= held_op;
  end

  assign rsp_busy = rsp_valid;

endmodule : smc_rd_capture

`default_nettype wire

//--- logic/smc_req_hold.sv
/*
 * host request holding register
 * takes one request on the valid/ready handshake and keeps it
 * stable on the memory side until the sram cycle has finished
 */
`timescale 1ns/100ps
`default_nettype none

module smc_req_hold (
  input  wire                                  hclk,
  input  wire                                  rst,
  // host request
  input  wire                                  req_valid,
  output logic                                 req_ready,
  input  wire smc_bus_pkg::smc_op_e            req_op,
  input  wire [smc_bus_pkg::ADDR_W-1:0]        req_addr,
  input  wire [smc_bus_pkg::DATA_W-1:0]        req_wdata,
  input  wire [smc_bus_pkg::LANES-1:0]         req_be,
  // cycle and response status
  input  wire                                  cycle_done,
  input  wire                                  rsp_busy,
  // held request
  output logic                                 held_valid,
  output smc_bus_pkg::smc_op_e                 held_op,
  output logic [smc_bus_pkg::ADDR_W-1:0]       held_addr,
  output logic [smc_bus_pkg::DATA_W-1:0]       held_wdata,
  output logic [smc_bus_pkg::LANES-1:0]        held_be
);

  logic accept;

  // one request in flight, shared pins
  // no new request while a response waits
  assign req_ready = !held_valid && !rsp_busy;
  assign accept    = req_valid && req_ready;

  // occupancy flag
  always_ff @(posedge hclk)
  begin
    if (rst)
      held_valid <= 1'b0;
    else if (accept)
      held_valid <= 1'b1;
    else if (cycle_done)
      held_valid <= 1'b0;
  end

  // request payload, also drives mem_addr and mem_wdata
  always_ff @(posedge hclk)
  begin
    if (accept)
    begin
      held_op    <= req_op;
      held_addr  <= req_addr;
      held_wdata <= req_wdata;
      held_be    <= req_be;
    end
  end

endmodule : smc_req_hold

`default_nettype wire

//--- logic/smc_timing_pkg.sv
/*
 * memory cycle definitions for the static memory controller
 * cycle states and the width of the phase counters
 */
`default_nettype none

package smc_timing_pkg;

  // ----------------------------------------
  // phase timing
  // ----------------------------------------

  // counter width, phases run 1 to 15 clocks
  localparam int PHASE_W = 4;

  // ----------------------------------------
  // cycle states
  // ----------------------------------------

  // setup, strobe and hold are the pin phases
  // done is a single turnaround clock before idle
  typedef enum logic [2:0] {
    ST_IDLE   = 3'd0,
    ST_SETUP  = 3'd1,
    ST_STROBE = 3'd2,
    ST_HOLD   = 3'd3,
    ST_DONE   = 3'd4
  } smc_state_e;

endpackage : smc_timing_pkg

`default_nettype wire

//--- logic/smc_top.sv
/*
 * static memory controller top
 * single word host requests to one asynchronous sram cycle each
 */
`timescale 1ns/100ps
`default_nettype none

module smc_top #(
  parameter logic [smc_timing_pkg::PHASE_W-1:0] SETUP_CYCLES  = 4'd2,
  parameter logic [smc_timing_pkg::PHASE_W-1:0] STROBE_CYCLES = 4'd3,
  parameter logic [smc_timing_pkg::PHASE_W-1:0] HOLD_CYCLES   = 4'd1
) (
  input  wire                                  hclk,
  input  wire                                  rst,
  // host request
  input  wire                                  req_valid,
  output logic                                 req_ready,
  input  wire smc_bus_pkg::smc_op_e            req_op,
  input  wire [smc_bus_pkg::ADDR_W-1:0]        req_addr,
  input  wire [smc_bus_pkg::DATA_W-1:0]        req_wdata,
  input  wire [smc_bus_pkg::LANES-1:0]         req_be,
  // host response
  output logic                                 rsp_valid,
  input  wire                                  rsp_ready,
  output smc_bus_pkg::smc_op_e                 rsp_op,
  output logic [smc_bus_pkg::DATA_W-1:0]       rsp_rdata,
  // sram pins
  output logic [smc_bus_pkg::ADDR_W-1:0]       mem_addr,
  output logic [smc_bus_pkg::DATA_W-1:0]       mem_wdata,
  output logic                                 mem_wdata_oe,
  input  wire [smc_bus_pkg::DATA_W-1:0]        mem_rdata,
  output logic                                 smc_n_cs,
  output logic                                 smc_n_oe,
  output logic                                 smc_n_wr,
  output logic [smc_bus_pkg::LANES-1:0]        smc_n_we
);

  import smc_bus_pkg::*;

  // ----------------------------------------
  // internal connections
  // ----------------------------------------

  logic              held_valid;
  smc_op_e           held_op;
  logic [LANES-1:0]  held_be;
  logic              r_full;
  logic              n_r_wr;
  logic [LANES-1:0]  n_r_we;
  logic              capture;
  logic              cycle_done;
  logic              rsp_busy;

  // address and write data go straight from the holding register
  smc_req_hold smc_req_hold_inst (
    .hclk       (hclk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_be     (req_be),
    .cycle_done (cycle_done),
    .rsp_busy   (rsp_busy),
    .held_valid (held_valid),
    .held_op    (held_op),
    .held_addr  (mem_addr),
    .held_wdata (mem_wdata),
    .held_be    (held_be)
  );

  smc_cycle_fsm #(
    .SETUP_CYCLES  (SETUP_CYCLES),
    .STROBE_CYCLES (STROBE_CYCLES),
    .HOLD_CYCLES   (HOLD_CYCLES)
  ) smc_cycle_fsm_inst (
    .hclk         (hclk),
    .rst          (rst),
    .held_valid   (held_valid),
    .held_op      (held_op),
    .held_be      (held_be),
    .r_full       (r_full),
    .n_r_wr       (n_r_wr),
    .n_r_we       (n_r_we),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .mem_wdata_oe (mem_wdata_oe),
    .capture      (capture),
    .cycle_done   (cycle_done)
  );

  smc_wr_enable smc_wr_enable_inst (
    .hclk     (hclk),
    .rst      (rst),
    .r_full   (r_full),
    .n_r_wr   (n_r_wr),
    .n_r_we   (n_r_we),
    .smc_n_wr (smc_n_wr),
    .smc_n_we (smc_n_we)
  );

  smc_rd_capture smc_rd_capture_inst (
    .hclk       (hclk),
    .rst        (rst),
    .capture    (capture),
    .cycle_done (cycle_done),
    .held_op    (held_op),
    .mem_rdata  (mem_rdata),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_op     (rsp_op),
    .rsp_rdata  (rsp_rdata),
    .rsp_busy   (rsp_busy)
  );

endmodule : smc_top

`default_nettype wire

//--- logic/smc_wr_enable.sv
/*
 * write enable stage
 * gates raw write strobe and byte enables with the full cycle
 * phase and registers them onto the active low pins
 */
`timescale 1ns/100ps
`default_nettype none

module smc_wr_enable (
  input  wire                                  hclk,
  input  wire                                  rst,
  // full cycle phase from the sequencer
  input  wire                                  r_full,
  // raw active low strobes
  input  wire                                  n_r_wr,
  input  wire [smc_bus_pkg::LANES-1:0]         n_r_we,
  // pins, active low
  output logic                                 smc_n_wr,
  output logic [smc_bus_pkg::LANES-1:0]        smc_n_we
);

  import smc_bus_pkg::*;

  logic [LANES-1:0] lane_gate_n;

  // high outside the strobe phase forces every lane inactive
  assign lane_gate_n = {LANES{~r_full}};

  // registered so the pins never glitch between phases
  always_ff @(posedge hclk)
  begin
    if (rst)
    begin
      smc_n_wr <= 1'b1;
      smc_n_we <= '1;
    end
    else
    begin
      smc_n_wr <= ~r_full | n_r_wr;
      // disabled lanes stay high through the raw enables
      smc_n_we <= lane_gate_n | n_r_we;
    end
  end

endmodule : smc_wr_enable

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the memory controller testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module smc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vsmc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0

//--- verif/smc_sram_model.sv
/*
 * behavioral asynchronous sram
 * byte lane writes on the rising write strobe, read data driven
 * while chip select and output enable are both low
 */
`timescale 1ns/100ps
`default_nettype none

module smc_sram_model (
  input  wire                                  smc_n_cs,
  input  wire                                  smc_n_oe,
  input  wire                                  smc_n_wr,
  input  wire [smc_bus_pkg::LANES-1:0]         smc_n_we,
  input  wire [smc_bus_pkg::ADDR_W-1:0]        mem_addr,
  input  wire [smc_bus_pkg::DATA_W-1:0]        mem_wdata,
  input  wire                                  mem_wdata_oe,
  output logic [smc_bus_pkg::DATA_W-1:0]       mem_rdata
);

  import smc_bus_pkg::*;

  // whole address space, one word per address
  logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];
  // byte enables seen during the current strobe
  logic [LANES-1:0]  lanes_n;

  // fill pattern mixes every address bit into both halves
  initial
  begin
    int i;
    lanes_n = '1;
    for (i = 0; i < (1 << ADDR_W); i++)
      mem[i] = {i[15:0] ^ 16'h5ac3, ~i[15:0]};
  end

  // byte enables settle just after the strobe falls
  always @(negedge smc_n_wr)
  begin
    #1;
    lanes_n = smc_n_we;
  end

  // write happens on the trailing edge of the strobe
  always @(posedge smc_n_wr)
  begin
    int lane;
    if (!smc_n_cs && mem_wdata_oe)
    begin
      for (lane = 0; lane < LANES; lane++)
        if (!lanes_n[lane])
          mem[mem_addr][8*lane +: 8] = mem_wdata[8*lane +: 8];
    end
    lanes_n = '1;
  end

  // all ones when the data bus is not driven
  assign mem_rdata = (!smc_n_cs && !smc_n_oe) ? mem[mem_addr] : '1;

endmodule : smc_sram_model

`default_nettype wire

//--- verif/smc_tb.sv
/*
 * static memory controller testbench
 * directed and random single word requests against a reference
 * memory, with pin shape and latency checks
 */
`timescale 1ns/100ps
`default_nettype none

module smc_tb;

  import smc_bus_pkg::*;

  // ----------------------------------------
  // timing and test sizes
  // ----------------------------------------

  localparam logic [3:0] SETUP  = 4'd2;
  localparam logic [3:0] STROBE = 4'd3;
  localparam logic [3:0] HOLD   = 4'd1;
  localparam int CS_CYCLES  = int'(SETUP) + int'(STROBE) + int'(HOLD);
  // accept edge to rsp_valid
  localparam int LATENCY    = CS_CYCLES + 3;
  localparam int TIMEOUT    = 100;
  localparam int NUM_RANDOM = 300;
  // 16 word window somewhere mid memory
  localparam logic [ADDR_W-1:0] BASE = 16'h3a40;

  logic              hclk;
  logic              rst;
  logic              req_valid;
  logic              req_ready;
  smc_op_e           req_op;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic [LANES-1:0]  req_be;
  logic              rsp_valid;
  logic              rsp_ready;
  smc_op_e           rsp_op;
  logic [DATA_W-1:0] rsp_rdata;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic              mem_wdata_oe;
  logic [DATA_W-1:0] mem_rdata;
  logic              smc_n_cs;
  logic              smc_n_oe;
  logic              smc_n_wr;
  logic [LANES-1:0]  smc_n_we;

  // reference memory for the window
  logic [DATA_W-1:0] ref_mem [0:15];
  logic [31:0]       rng_state;

  int resp_errs = 0;
  int pin_errs  = 0;
  int timeouts  = 0;

  // pin monitor totals that only count up
  int      cs_total    = 0;
  int      wr_total    = 0;
  int      oe_total    = 0;
  int      strobe_mark = 0;
  logic    strobe_prev = 1'b0;
  logic    mon_en      = 1'b0;
  smc_op_e cur_op      = OP_READ;
  logic [LANES-1:0] cur_be = '0;

  smc_tb_clock clock_inst (
    .hclk (hclk)
  );

  smc_top #(
    .SETUP_CYCLES  (SETUP),
    .STROBE_CYCLES (STROBE),
    .HOLD_CYCLES   (HOLD)
  ) smc_top_inst (
    .hclk         (hclk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_op       (req_op),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_be       (req_be),
    .rsp_valid    (rsp_valid),
    .rsp_ready    (rsp_ready),
    .rsp_op       (rsp_op),
    .rsp_rdata    (rsp_rdata),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_wdata_oe (mem_wdata_oe),
    .mem_rdata    (mem_rdata),
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .smc_n_wr     (smc_n_wr),
    .smc_n_we     (smc_n_we)
  );

  smc_sram_model sram_inst (
    .smc_n_cs     (smc_n_cs),
    .smc_n_oe     (smc_n_oe),
    .smc_n_wr     (smc_n_wr),
    .smc_n_we     (smc_n_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_wdata_oe (mem_wdata_oe),
    .mem_rdata    (mem_rdata)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // power-up contents of the sram model
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return {addr ^ 16'h5ac3, ~addr};
  endfunction

  // per lane merge of a write into a stored word
  function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [LANES-1:0] be);
    logic [DATA_W-1:0] w;
    int l;
    w = old_word;
    for (l = 0; l < LANES; l++)
      if (be[l])
        w[8*l +: 8] = new_word[8*l +: 8];
    return w;
  endfunction

  // ----------------------------------------
  // pin monitor sampling mid cycle
  // ----------------------------------------

  always @(negedge hclk)
  begin
    logic strobe_low;
    strobe_low = !smc_n_wr || !smc_n_oe;
    if (mon_en)
    begin
      if (!smc_n_cs)
        cs_total++;
      if (!smc_n_wr)
        wr_total++;
      if (!smc_n_oe)
        oe_total++;
      // cs cycles seen up to the first strobe cycle
      if (strobe_low && !strobe_prev)
        strobe_mark = cs_total;
      strobe_prev = strobe_low;
      assert (!strobe_low || !smc_n_cs)
      else
      begin
        pin_errs++;
        $display("FAILED %0t ns: strobe active outside chip select", $time);
      end
      if (cur_op == OP_WRITE)
      begin
        assert (smc_n_oe)
        else
        begin
          pin_errs++;
          $display("FAILED %0t ns: output enable low during a write", $time);
        end
        assert (smc_n_we == (smc_n_wr ? 4'hf : ~cur_be))
        else
        begin
          pin_errs++;
          $display("FAILED %0t ns: byte enables %b with write strobe %b, lanes %b",
                   $time, smc_n_we, smc_n_wr, cur_be);
        end
      end
      else
      begin
        assert (smc_n_wr && (smc_n_we == 4'hf))
        else
        begin
          pin_errs++;
          $display("FAILED %0t ns: write strobe low during a read", $time);
        end
      end
      assert (mem_wdata_oe == (!smc_n_cs && (cur_op == OP_WRITE)))
      else
      begin
        pin_errs++;
        $display("FAILED %0t ns: mem_wdata_oe is %b", $time, mem_wdata_oe);
      end
    end
  end

  // ----------------------------------------
  // one request, its response and checks
  // ----------------------------------------

  task automatic run_request(input smc_op_e op, input logic [3:0] idx,
                             input logic [DATA_W-1:0] wdata, input logic [LANES-1:0] be,
                             input int stall);
    int n;
    int cs_snap;
    int wr_snap;
    int oe_snap;
    logic [DATA_W-1:0] expect_data;
    logic [DATA_W-1:0] first_data;
    n = 0;
    while (!req_ready && (n < TIMEOUT))
    begin
      @(posedge hclk);
      #2;
      n++;
    end
    if (!req_ready)
    begin
      timeouts++;
      $display("timeout: req_ready stayed low for %0d cycles", TIMEOUT);
      return;
    end
    cs_snap   = cs_total;
    wr_snap   = wr_total;
    oe_snap   = oe_total;
    cur_op    = op;
    cur_be    = (op == OP_WRITE) ? be : '0;
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = BASE + {12'h000, idx};
    req_wdata = wdata;
    req_be    = be;
    // accept edge
    @(posedge hclk);
    #2;
    req_valid = 1'b0;
    if (op == OP_WRITE)
    begin
      ref_mem[idx] = merge_lanes(ref_mem[idx], wdata, be);
      expect_data  = '0;
    end
    else
      expect_data = ref_mem[idx];
    n = 0;
    while (!rsp_valid && (n < TIMEOUT))
    begin
      @(posedge hclk);
      #2;
      n++;
    end
    if (!rsp_valid)
    begin
      timeouts++;
      $display("timeout: no response within %0d cycles", TIMEOUT);
      return;
    end
    assert (n == LATENCY)
    else
    begin
      resp_errs++;
      $display("FAILED %0t ns: response after %0d cycles, expected %0d", $time, n, LATENCY);
    end
    // hold off the response and watch it stay put
    first_data = rsp_rdata;
    repeat (stall)
    begin
      @(posedge hclk);
      #2;
      assert (rsp_valid && (rsp_rdata == first_data) && !req_ready && smc_n_cs)
      else
      begin
        resp_errs++;
        $display("FAILED %0t ns: response or pins moved under back-pressure", $time);
      end
    end
    assert ((rsp_op == op) && (rsp_rdata == expect_data))
    else
    begin
      resp_errs++;
      $display("FAILED %0t ns: addr %h op %0d data %h, expected op %0d data %h",
               $time, req_addr, rsp_op, rsp_rdata, op, expect_data);
    end
    rsp_ready = 1'b1;
    @(posedge hclk);
    #2;
    rsp_ready = 1'b0;
    assert (!rsp_valid && req_ready)
    else
    begin
      resp_errs++;
      $display("FAILED %0t ns: response not released after handshake", $time);
    end
    // pin window lengths for this cycle
    assert ((cs_total - cs_snap == CS_CYCLES) && (strobe_mark - cs_snap == int'(SETUP) + 1))
    else
    begin
      resp_errs++;
      $display("FAILED %0t ns: chip select %0d cycles, strobe starts at cycle %0d",
               $time, cs_total - cs_snap, strobe_mark - cs_snap);
    end
    assert (((op == OP_WRITE) ? (wr_total - wr_snap) : (oe_total - oe_snap)) == int'(STROBE))
    else
    begin
      resp_errs++;
      $display("FAILED %0t ns: strobe width wrong, wr %0d oe %0d cycles",
               $time, wr_total - wr_snap, oe_total - oe_snap);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial
  begin
    int i;
    int stall;
    logic [31:0] r0;
    logic [31:0] r1;
    // times in the error lines are whole ns
    $timeformat(-9, 0, "", 0);
    rst       = 1'b1;
    req_valid = 1'b0;
    req_op    = OP_READ;
    req_addr  = '0;
    req_wdata = '0;
    req_be    = '0;
    rsp_ready = 1'b0;
    rng_state = 32'h06ee_c3f7;
    for (i = 0; i < 16; i++)
      ref_mem[i] = fill_word(BASE + i[ADDR_W-1:0]);
    // two reset edges
    repeat (2) @(posedge hclk);
    #2;
    rst    = 1'b0;
    mon_en = 1'b1;
    assert (smc_n_cs && smc_n_oe && smc_n_wr && (smc_n_we == 4'hf) && !mem_wdata_oe
            && req_ready && !rsp_valid)
    else
    begin
      resp_errs++;
      $display("FAILED %0t ns: outputs not idle after reset", $time);
    end
    // full word write then read back
    run_request(OP_WRITE, 4'd3, 32'h1357_9bdf, 4'hf, 0);
    run_request(OP_READ, 4'd3, '0, 4'hf, 0);
    // partial lanes merge into the stored word
    run_request(OP_WRITE, 4'd3, 32'haabb_ccdd, 4'b0101, 0);
    run_request(OP_READ, 4'd3, '0, 4'hf, 0);
    // back-pressure on both opcodes
    run_request(OP_READ, 4'd9, '0, 4'hf, 4);
    run_request(OP_WRITE, 4'd9, 32'h0f1e_2d3c, 4'b1000, 3);
    run_request(OP_READ, 4'd9, '0, 4'hf, 2);
    for (i = 0; (i < NUM_RANDOM) && (timeouts == 0); i++)
    begin
      rng_state = xorshift32(rng_state);
      r0        = rng_state;
      rng_state = xorshift32(rng_state);
      r1        = rng_state;
      stall     = int'(r0[14:12]) % 5;
      run_request(smc_op_e'(r0[0]), r0[7:4], r1, r0[11:8], stall);
    end
    $display("errors: response %0d, pin %0d, timeout %0d", resp_errs, pin_errs, timeouts);
    if ((resp_errs + pin_errs + timeouts) == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule : smc_tb

`default_nettype wire

//--- verif/smc_tb_clock.sv
/*
 * testbench clock source
 * free running hclk for the memory controller testbench
 */
`timescale 1ns/100ps
`default_nettype none

module smc_tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic hclk
);

  // first rising edge half a period in
  initial
  begin
    hclk = 1'b0;
    forever
      #(PERIOD_NS / 2) hclk = ~hclk;
  end

endmodule : smc_tb_clock

`default_nettype wire

//--- verilog.f
logic/smc_bus_pkg.sv
logic/smc_timing_pkg.sv
logic/smc_req_hold.sv
logic/smc_cycle_fsm.sv
logic/smc_wr_enable.sv
logic/smc_rd_capture.sv
logic/smc_top.sv
verif/smc_tb_clock.sv
verif/smc_sram_model.sv
verif/smc_tb.sv
